// ==== dispatch_pkg.sv ====
// dispatch package: lane count, widths, vector typedefs, select enums, port structs
package dispatch_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int DP_NUM        = 2;
    localparam int PHY_REG_NUM   = 64;
    localparam int ROB_ENTRY_NUM = 32;
    localparam int ARCH_REG_NUM  = 32;

    // derived field widths
    localparam int DP_CNT_W   = $clog2(DP_NUM + 1);
    localparam int TAG_W      = $clog2(PHY_REG_NUM);
    localparam int ROB_IDX_W  = $clog2(ROB_ENTRY_NUM);
    localparam int ARCH_REG_W = $clog2(ARCH_REG_NUM);

    // ========================================
    // vector types
    // ========================================
    // dispatch / free-entry count, 0..DP_NUM
    typedef logic [DP_CNT_W-1:0]   dp_cnt_t;
    typedef logic [31:0]           inst_t;
    typedef logic [31:0]           pc_t;
    // physical register tag
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // x0 doubles as the unused index
    localparam arch_reg_t ZERO_REG = '0;

    // ========================================
    // select enums
    // ========================================
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_ZERO = 2'h2
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_SLT    = 4'h2,
        ALU_SLTU   = 4'h3,
        ALU_AND    = 4'h4,
        ALU_OR     = 4'h5,
        ALU_XOR    = 4'h6,
        ALU_SLL    = 4'h7,
        ALU_SRL    = 4'h8,
        ALU_SRA    = 4'h9,
        ALU_MUL    = 4'ha,
        ALU_MULH   = 4'hb,
        ALU_MULHSU = 4'hc,
        ALU_MULHU  = 4'hd
    } alu_func_e;

    // ========================================
    // decode result and port structs
    // ========================================
    // 32 bits, class flags at the bottom
    typedef struct packed {
        opa_sel_e  opa;
        opb_sel_e  opb;
        alu_func_e alu_func;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      rd_mem;
        logic      wr_mem;
        logic      cond_br;
        logic      uncond_br;
        logic      halt;
        logic      illegal;
        logic      mult;
        logic      alu;
    } dec_ctrl_t;

    // rob: free slots and the slot index per lane
    typedef struct packed {
        dp_cnt_t                    free_num;
        rob_idx_t [DP_NUM-1:0]      rob_idx;
    } rob_dp_t;

    // free list: free tags and one new tag per lane
    typedef struct packed {
        dp_cnt_t                    free_num;
        tag_t     [DP_NUM-1:0]      tag;
    } fl_dp_t;

    // fetch queue: valid insts and their pcs
    typedef struct packed {
        dp_cnt_t                    valid_num;
        inst_t    [DP_NUM-1:0]      inst;
        pc_t      [DP_NUM-1:0]      pc;
    } fiq_dp_t;

    typedef struct packed {
        dp_cnt_t free_num;
    } rs_dp_t;

    // map table answer, one per lane
    typedef struct packed {
        tag_t tag1;
        logic tag1_ready;
        tag_t tag2;
        logic tag2_ready;
        tag_t tag_old;
    } mt_dp_t;

    // rename request, one per lane
    typedef struct packed {
        logic      wr_en;
        tag_t      tag;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } dp_mt_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        inst_t     inst;
        dec_ctrl_t ctrl;
        tag_t      tag;
        tag_t      tag1;
        logic      tag1_ready;
        tag_t      tag2;
        logic      tag2_ready;
        rob_idx_t  rob_idx;
    } rs_entry_t;

    typedef struct packed {
        dp_cnt_t                    dp_num;
        rs_entry_t [DP_NUM-1:0]     entry;
    } dp_rs_t;

    typedef struct packed {
        dp_cnt_t                    dp_num;
        logic      [DP_NUM-1:0]     valid;
        pc_t       [DP_NUM-1:0]     pc;
        arch_reg_t [DP_NUM-1:0]     rd;
        tag_t      [DP_NUM-1:0]     tag;
        tag_t      [DP_NUM-1:0]     tag_old;
    } dp_rob_t;

endpackage

// ==== dispatch_count.sv ====
// dispatch count: minimum of rob, free list, fetch queue and rs counts, clamped to lanes
`timescale 1ns/1ps

module dispatch_count (
    input  dispatch_pkg::dp_cnt_t rob_free_i,
    input  dispatch_pkg::dp_cnt_t fl_free_i,
    input  dispatch_pkg::dp_cnt_t fiq_valid_i,
    input  dispatch_pkg::dp_cnt_t rs_free_i,
    output dispatch_pkg::dp_cnt_t dp_num_o
);
    import dispatch_pkg::*;

    // first level of the tree
    dp_cnt_t comp_tmp1;
    dp_cnt_t comp_tmp2;
    // tree output before clamping
    dp_cnt_t comp_out;

    function automatic dp_cnt_t cnt_min(input dp_cnt_t a, input dp_cnt_t b);
        return (a < b) ? a : b;
    endfunction

    // ========================================
    // comparator tree
    // ========================================
    // rob vs fetch queue, free list vs rs
    assign comp_tmp1 = cnt_min(rob_free_i, fiq_valid_i);
    assign comp_tmp2 = cnt_min(fl_free_i, rs_free_i);
    assign comp_out  = cnt_min(comp_tmp1, comp_tmp2);

    // a unit may report more room than there are lanes
    always_comb begin
        if (comp_out > dp_cnt_t'(DP_NUM)) begin
            dp_num_o = dp_cnt_t'(DP_NUM);
        end else begin
            dp_num_o = comp_out;
        end
    end

    // never more lanes than exist, nor more than any unit can take
    always_comb begin
        a_num_bound: assert (dp_num_o <= dp_cnt_t'(DP_NUM) && dp_num_o <= rob_free_i &&
                             dp_num_o <= fl_free_i && dp_num_o <= fiq_valid_i &&
                             dp_num_o <= rs_free_i)
            else $error("dispatch count above lane count or a free count");
    end

endmodule

// ==== rv32_decoder.sv ====
// rv32im decoder lane: operand selects, alu function, class flags, register indices
`timescale 1ns/1ps

module rv32_decoder (
    input  dispatch_pkg::inst_t     inst_i,
    input  logic                    lane_valid_i,
    output dispatch_pkg::dec_ctrl_t ctrl_o
);
    import dispatch_pkg::*;

    // which register fields this format reads or writes
    logic rd_used;
    logic rs1_used;
    logic rs2_used;

    // base integer op from funct3, alt picks sub / sra
    function automatic alu_func_e int_func(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // m extension, multiplies only
    function automatic alu_func_e mul_func(input logic [1:0] funct3_lo);
        case (funct3_lo)
            2'b00:   return ALU_MUL;
            2'b01:   return ALU_MULH;
            2'b10:   return ALU_MULHSU;
            default: return ALU_MULHU;
        endcase
    endfunction

    // ========================================
    // decode table
    // ========================================
    always_comb begin
        // no-op defaults, also what an idle lane shows
        ctrl_o           = '0;
        ctrl_o.opa       = OPA_IS_RS1;
        ctrl_o.opb       = OPB_IS_RS2;
        ctrl_o.alu_func  = ALU_ADD;
        ctrl_o.alu       = 1'b1;
        rd_used          = 1'b0;
        rs1_used         = 1'b0;
        rs2_used         = 1'b0;

        if (lane_valid_i) begin
            casez (inst_i)
                // lui
                32'b???????_?????_?????_???_?????_0110111: begin
                    rd_used    = 1'b1;
                    ctrl_o.opa = OPA_IS_ZERO;
                    ctrl_o.opb = OPB_IS_U_IMM;
                end
                // auipc
                32'b???????_?????_?????_???_?????_0010111: begin
                    rd_used    = 1'b1;
                    ctrl_o.opa = OPA_IS_PC;
                    ctrl_o.opb = OPB_IS_U_IMM;
                end
                // jal, target from pc + j imm
                32'b???????_?????_?????_???_?????_1101111: begin
                    rd_used          = 1'b1;
                    ctrl_o.opa       = OPA_IS_PC;
                    ctrl_o.opb       = OPB_IS_J_IMM;
                    ctrl_o.uncond_br = 1'b1;
                    ctrl_o.alu       = 1'b0;
                end
                // jalr
                32'b???????_?????_?????_000_?????_1100111: begin
                    rd_used          = 1'b1;
                    rs1_used         = 1'b1;
                    ctrl_o.opb       = OPB_IS_I_IMM;
                    ctrl_o.uncond_br = 1'b1;
                    ctrl_o.alu       = 1'b0;
                end
                // beq bne / blt bge bltu bgeu
                32'b???????_?????_?????_00?_?????_1100011,
                32'b???????_?????_?????_1??_?????_1100011: begin
                    rs1_used       = 1'b1;
                    rs2_used       = 1'b1;
                    ctrl_o.opa     = OPA_IS_PC;
                    ctrl_o.opb     = OPB_IS_B_IMM;
                    ctrl_o.cond_br = 1'b1;
                    ctrl_o.alu     = 1'b0;
                end
                // lb lh / lw / lbu lhu
                32'b???????_?????_?????_00?_?????_0000011,
                32'b???????_?????_?????_010_?????_0000011,
                32'b???????_?????_?????_10?_?????_0000011: begin
                    rd_used       = 1'b1;
                    rs1_used      = 1'b1;
                    ctrl_o.opb    = OPB_IS_I_IMM;
                    ctrl_o.rd_mem = 1'b1;
                    ctrl_o.alu    = 1'b0;
                end
                // sb sh / sw
                32'b???????_?????_?????_00?_?????_0100011,
                32'b???????_?????_?????_010_?????_0100011: begin
                    rs1_used      = 1'b1;
                    rs2_used      = 1'b1;
                    ctrl_o.opb    = OPB_IS_S_IMM;
                    ctrl_o.wr_mem = 1'b1;
                    ctrl_o.alu    = 1'b0;
                end
                // addi, slti sltiu, xori ori, andi
                32'b???????_?????_?????_000_?????_0010011,
                32'b???????_?????_?????_01?_?????_0010011,
                32'b???????_?????_?????_1?0_?????_0010011,
                32'b???????_?????_?????_111_?????_0010011: begin
                    rd_used         = 1'b1;
                    rs1_used        = 1'b1;
                    ctrl_o.opb      = OPB_IS_I_IMM;
                    ctrl_o.alu_func = int_func(inst_i[14:12], 1'b0);
                end
                // slli, srli srai; bit 30 splits the right shifts
                32'b0000000_?????_?????_001_?????_0010011,
                32'b0?00000_?????_?????_101_?????_0010011: begin
                    rd_used         = 1'b1;
                    rs1_used        = 1'b1;
                    ctrl_o.opb      = OPB_IS_I_IMM;
                    ctrl_o.alu_func = int_func(inst_i[14:12], inst_i[30]);
                end
                // register ops, then sub and sra
                32'b0000000_?????_?????_???_?????_0110011,
                32'b0100000_?????_?????_000_?????_0110011,
                32'b0100000_?????_?????_101_?????_0110011: begin
                    rd_used         = 1'b1;
                    rs1_used        = 1'b1;
                    rs2_used        = 1'b1;
                    ctrl_o.alu_func = int_func(inst_i[14:12], inst_i[30]);
                end
                // mul mulh mulhsu mulhu, no divide unit
                32'b0000001_?????_?????_0??_?????_0110011: begin
                    rd_used         = 1'b1;
                    rs1_used        = 1'b1;
                    rs2_used        = 1'b1;
                    ctrl_o.alu_func = mul_func(inst_i[13:12]);
                    ctrl_o.mult     = 1'b1;
                    ctrl_o.alu      = 1'b0;
                end
                // wfi stops the core
                32'h1050_0073: begin
                    ctrl_o.halt = 1'b1;
                end
                // csr and anything unknown
                default: begin
                    ctrl_o.illegal = 1'b1;
                end
            endcase
        end

        // register indices only where the format has them
        ctrl_o.rd  = rd_used  ? inst_i[11:7]  : ZERO_REG;
        ctrl_o.rs1 = rs1_used ? inst_i[19:15] : ZERO_REG;
        ctrl_o.rs2 = rs2_used ? inst_i[24:20] : ZERO_REG;
    end

    // one functional unit class per instruction
    always_comb begin
        a_one_class: assert ($onehot0({ctrl_o.rd_mem, ctrl_o.wr_mem, ctrl_o.cond_br,
                                       ctrl_o.uncond_br, ctrl_o.mult, ctrl_o.alu}))
            else $error("decoder set more than one unit class");
    end

endmodule

// ==== dispatch_stage.sv ====
// dispatch stage top: decoder lanes, map table requests, registered rs and rob packets
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                   clock_i,
    input  logic                   rst_n_i,
    input  dispatch_pkg::rob_dp_t  rob_dp_i,
    input  dispatch_pkg::fl_dp_t   fl_dp_i,
    input  dispatch_pkg::fiq_dp_t  fiq_dp_i,
    input  dispatch_pkg::rs_dp_t   rs_dp_i,
    input  dispatch_pkg::mt_dp_t   mt_dp_i [dispatch_pkg::DP_NUM-1:0],
    output dispatch_pkg::dp_mt_t   dp_mt_o [dispatch_pkg::DP_NUM-1:0],
    output dispatch_pkg::dp_rs_t   dp_rs_o,
    output dispatch_pkg::dp_rob_t  dp_rob_o
);
    import dispatch_pkg::*;

    // lanes that dispatch this cycle
    dp_cnt_t           dp_num;
    logic [DP_NUM-1:0] lane_valid;
    dec_ctrl_t         dec_ctrl [DP_NUM-1:0];

    // packets before the output register
    dp_rs_t            dp_rs_d;
    dp_rob_t           dp_rob_d;

    // ========================================
    // structural hazard count
    // ========================================
    dispatch_count dispatch_count_inst (
        .rob_free_i  (rob_dp_i.free_num),
        .fl_free_i   (fl_dp_i.free_num),
        .fiq_valid_i (fiq_dp_i.valid_num),
        .rs_free_i   (rs_dp_i.free_num),
        .dp_num_o    (dp_num)
    );

    // ========================================
    // decoder lanes
    // ========================================
    for (genvar lane = 0; lane < DP_NUM; lane++) begin : g_lane
        // first dp_num lanes, in order
        assign lane_valid[lane] = dp_cnt_t'(lane) < dp_num;

        rv32_decoder rv32_decoder_inst (
            .inst_i       (fiq_dp_i.inst[lane]),
            .lane_valid_i (lane_valid[lane]),
            .ctrl_o       (dec_ctrl[lane])
        );
    end

    // map table rename requests, same cycle
    always_comb begin
        for (int i = 0; i < DP_NUM; i++) begin
            // no renames while held in reset
            dp_mt_o[i].wr_en = lane_valid[i] & rst_n_i;
            dp_mt_o[i].tag   = fl_dp_i.tag[i];
            dp_mt_o[i].rd    = dec_ctrl[i].rd;
            dp_mt_o[i].rs1   = dec_ctrl[i].rs1;
            dp_mt_o[i].rs2   = dec_ctrl[i].rs2;
        end
    end

    // ========================================
    // rs and rob packet assembly
    // ========================================
    always_comb begin
        dp_rs_d.dp_num  = dp_num;
        dp_rob_d.dp_num = dp_num;
        for (int i = 0; i < DP_NUM; i++) begin
            // rs entry, source tags come back from the map table
            dp_rs_d.entry[i].valid      = lane_valid[i];
            dp_rs_d.entry[i].pc         = fiq_dp_i.pc[i];
            dp_rs_d.entry[i].inst       = fiq_dp_i.inst[i];
            dp_rs_d.entry[i].ctrl       = dec_ctrl[i];
            dp_rs_d.entry[i].tag        = fl_dp_i.tag[i];
            dp_rs_d.entry[i].tag1       = mt_dp_i[i].tag1;
            dp_rs_d.entry[i].tag1_ready = mt_dp_i[i].tag1_ready;
            dp_rs_d.entry[i].tag2       = mt_dp_i[i].tag2;
            dp_rs_d.entry[i].tag2_ready = mt_dp_i[i].tag2_ready;
            dp_rs_d.entry[i].rob_idx    = rob_dp_i.rob_idx[i];
            // rob entry, old tag freed at retire
            dp_rob_d.valid[i]   = lane_valid[i];
            dp_rob_d.pc[i]      = fiq_dp_i.pc[i];
            dp_rob_d.rd[i]      = dec_ctrl[i].rd;
            dp_rob_d.tag[i]     = fl_dp_i.tag[i];
            dp_rob_d.tag_old[i] = mt_dp_i[i].tag_old;
        end
    end

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            // only count and valids cleared, payload holds
            dp_rs_o.dp_num  <= '0;
            dp_rob_o.dp_num <= '0;
            dp_rob_o.valid  <= '0;
            for (int i = 0; i < DP_NUM; i++) begin
                dp_rs_o.entry[i].valid <= 1'b0;
            end
        end else begin
            dp_rs_o  <= dp_rs_d;
            dp_rob_o <= dp_rob_d;
        end
    end

    // dispatched lanes stay contiguous from lane 0
    for (genvar lane = 1; lane < DP_NUM; lane++) begin : g_order_chk
        a_valid_order: assert property (@(posedge clock_i) disable iff (!rst_n_i)
            dp_rs_o.entry[lane].valid |-> dp_rs_o.entry[lane-1].valid)
            else $error("registered lane %0d valid after an invalid lane", lane);
    end

endmodule

// ==== tb_dispatch_stage.sv ====
// testbench for the dispatch stage: vector file reader, stimulus driver, compare tasks
`timescale 1ns/1ps

module tb_dispatch_stage;
    import dispatch_pkg::*;

    // ========================================
    // vector layout, one record per line
    // ========================================
    localparam int NUM_VEC      = 25;
    localparam int NUM_FIELD    = 31;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_VEC + 20;
    // field offsets inside a record
    localparam int F_ROB  = 0;
    localparam int F_FL   = 1;
    localparam int F_FIQ  = 2;
    localparam int F_RS   = 3;
    localparam int F_INST = 4;
    localparam int F_PC   = 6;
    localparam int F_FTAG = 8;
    localparam int F_RIDX = 10;
    // tag1 then tag2, per lane
    localparam int F_SRC  = 12;
    localparam int F_OLD  = 16;
    localparam int F_RDY  = 18;
    localparam int F_NUM  = 19;
    localparam int F_WR   = 20;
    // rd rs1 rs2 func flags, per lane
    localparam int F_EXP  = 21;

    logic    clock_i;
    logic    rst_n_i;
    rob_dp_t rob_dp;
    fl_dp_t  fl_dp;
    fiq_dp_t fiq_dp;
    rs_dp_t  rs_dp;
    mt_dp_t  mt_dp [DP_NUM-1:0];
    dp_mt_t  dp_mt [DP_NUM-1:0];
    dp_rs_t  dp_rs;
    dp_rob_t dp_rob;

    logic [31:0] vec_mem [0:NUM_VEC*NUM_FIELD-1];
    int          error_count;
    int          cycle_count;

    dispatch_stage dispatch_stage_inst (
        .clock_i  (clock_i),
        .rst_n_i  (rst_n_i),
        .rob_dp_i (rob_dp),
        .fl_dp_i  (fl_dp),
        .fiq_dp_i (fiq_dp),
        .rs_dp_i  (rs_dp),
        .mt_dp_i  (mt_dp),
        .dp_mt_o  (dp_mt),
        .dp_rs_o  (dp_rs),
        .dp_rob_o (dp_rob)
    );

    // 20 ns clock
    always #10 clock_i = ~clock_i;

    // run limit
    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Test failures found");
            $display("run hit the cycle limit of %0d before all vectors were checked",
                     MAX_CYCLES);
            $finish;
        end
    end

    function automatic logic [31:0] field(input int v, input int f);
        return vec_mem[v*NUM_FIELD + f];
    endfunction

    // operand a source by rv32 format, idle or illegal lanes keep rs1
    function automatic opa_sel_e opa_for_inst(input inst_t inst, input logic live);
        if (!live) begin
            return OPA_IS_RS1;
        end
        case (inst[6:0])
            7'b0110111:                         return OPA_IS_ZERO;
            7'b0010111, 7'b1101111, 7'b1100011: return OPA_IS_PC;
            default:                            return OPA_IS_RS1;
        endcase
    endfunction

    // operand b source by rv32 format, idle or illegal lanes keep rs2
    function automatic opb_sel_e opb_for_inst(input inst_t inst, input logic live);
        if (!live) begin
            return OPB_IS_RS2;
        end
        case (inst[6:0])
            7'b0110111, 7'b0010111:             return OPB_IS_U_IMM;
            7'b1101111:                         return OPB_IS_J_IMM;
            7'b1100111, 7'b0000011, 7'b0010011: return OPB_IS_I_IMM;
            7'b1100011:                         return OPB_IS_B_IMM;
            7'b0100011:                         return OPB_IS_S_IMM;
            default:                            return OPB_IS_RS2;
        endcase
    endfunction

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_cnt(input string name, input dp_cnt_t act, input dp_cnt_t exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_reg(input string name, input arch_reg_t act, input arch_reg_t exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t act, input tag_t exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t act, input rob_idx_t exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t act, input pc_t exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_inst(input string name, input inst_t act, input inst_t exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_func(input string name, input alu_func_e act, input alu_func_e exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_opa(input string name, input opa_sel_e act, input opa_sel_e exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_opb(input string name, input opb_sel_e act, input opb_sel_e exp);
        if (act !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, act, exp);
        end
    endtask

    // flag byte is rd_mem wr_mem cond_br uncond_br halt illegal mult alu
    task automatic check_flags(input string name, input dec_ctrl_t act, input logic [7:0] exp);
        logic [7:0] got;
        got = {act.rd_mem, act.wr_mem, act.cond_br, act.uncond_br,
               act.halt, act.illegal, act.mult, act.alu};
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ========================================
    // stimulus and checks
    // ========================================
    // called on a rising edge
    task automatic apply_vector(input int v);
        logic [31:0] rdy;
        rdy = field(v, F_RDY);
        rob_dp.free_num  <= dp_cnt_t'(field(v, F_ROB));
        fl_dp.free_num   <= dp_cnt_t'(field(v, F_FL));
        fiq_dp.valid_num <= dp_cnt_t'(field(v, F_FIQ));
        rs_dp.free_num   <= dp_cnt_t'(field(v, F_RS));
        for (int i = 0; i < DP_NUM; i++) begin
            fiq_dp.inst[i]       <= field(v, F_INST + i);
            fiq_dp.pc[i]         <= field(v, F_PC + i);
            fl_dp.tag[i]         <= tag_t'(field(v, F_FTAG + i));
            rob_dp.rob_idx[i]    <= rob_idx_t'(field(v, F_RIDX + i));
            mt_dp[i].tag1        <= tag_t'(field(v, F_SRC + 2*i));
            mt_dp[i].tag2        <= tag_t'(field(v, F_SRC + 2*i + 1));
            mt_dp[i].tag1_ready  <= rdy[2*i];
            mt_dp[i].tag2_ready  <= rdy[2*i + 1];
            mt_dp[i].tag_old     <= tag_t'(field(v, F_OLD + i));
        end
    endtask

    // same-cycle map table requests
    task automatic check_comb(input int v);
        logic [31:0] wr;
        wr = field(v, F_WR);
        for (int i = 0; i < DP_NUM; i++) begin
            check_bit("dp_mt_o.wr_en", dp_mt[i].wr_en, wr[i]);
            check_tag("dp_mt_o.tag", dp_mt[i].tag, tag_t'(field(v, F_FTAG + i)));
            check_reg("dp_mt_o.rd", dp_mt[i].rd, arch_reg_t'(field(v, F_EXP + 5*i)));
            check_reg("dp_mt_o.rs1", dp_mt[i].rs1, arch_reg_t'(field(v, F_EXP + 5*i + 1)));
            check_reg("dp_mt_o.rs2", dp_mt[i].rs2, arch_reg_t'(field(v, F_EXP + 5*i + 2)));
        end
    endtask

    // registered packets, one cycle behind vector p
    task automatic check_regd(input int p);
        logic [31:0] wr;
        logic [31:0] rdy;
        logic [7:0]  flg;
        logic        live;
        inst_t       inst;
        wr  = field(p, F_WR);
        rdy = field(p, F_RDY);
        check_cnt("dp_rs_o.dp_num", dp_rs.dp_num, dp_cnt_t'(field(p, F_NUM)));
        check_cnt("dp_rob_o.dp_num", dp_rob.dp_num, dp_cnt_t'(field(p, F_NUM)));
        for (int i = 0; i < DP_NUM; i++) begin
            flg  = 8'(field(p, F_EXP + 5*i + 4));
            inst = field(p, F_INST + i);
            // dispatched and legal, so the format picks the operands
            live = wr[i] & ~flg[2];
            check_bit("dp_rs_o.valid", dp_rs.entry[i].valid, wr[i]);
            check_bit("dp_rob_o.valid", dp_rob.valid[i], wr[i]);
            check_pc("dp_rs_o.pc", dp_rs.entry[i].pc, field(p, F_PC + i));
            check_pc("dp_rob_o.pc", dp_rob.pc[i], field(p, F_PC + i));
            check_inst("dp_rs_o.inst", dp_rs.entry[i].inst, inst);
            check_tag("dp_rs_o.tag", dp_rs.entry[i].tag, tag_t'(field(p, F_FTAG + i)));
            check_tag("dp_rs_o.tag1", dp_rs.entry[i].tag1, tag_t'(field(p, F_SRC + 2*i)));
            check_tag("dp_rs_o.tag2", dp_rs.entry[i].tag2, tag_t'(field(p, F_SRC + 2*i + 1)));
            check_bit("dp_rs_o.tag1_ready", dp_rs.entry[i].tag1_ready, rdy[2*i]);
            check_bit("dp_rs_o.tag2_ready", dp_rs.entry[i].tag2_ready, rdy[2*i + 1]);
            check_idx("dp_rs_o.rob_idx", dp_rs.entry[i].rob_idx,
                      rob_idx_t'(field(p, F_RIDX + i)));
            check_opa("dp_rs_o.opa", dp_rs.entry[i].ctrl.opa, opa_for_inst(inst, live));
            check_opb("dp_rs_o.opb", dp_rs.entry[i].ctrl.opb, opb_for_inst(inst, live));
            check_func("dp_rs_o.alu_func", dp_rs.entry[i].ctrl.alu_func,
                       alu_func_e'(field(p, F_EXP + 5*i + 3)));
            check_flags("dp_rs_o.flags", dp_rs.entry[i].ctrl, flg);
            check_reg("dp_rs_o.rd", dp_rs.entry[i].ctrl.rd, arch_reg_t'(field(p, F_EXP + 5*i)));
            check_reg("dp_rs_o.rs1", dp_rs.entry[i].ctrl.rs1,
                      arch_reg_t'(field(p, F_EXP + 5*i + 1)));
            check_reg("dp_rs_o.rs2", dp_rs.entry[i].ctrl.rs2,
                      arch_reg_t'(field(p, F_EXP + 5*i + 2)));
            check_reg("dp_rob_o.rd", dp_rob.rd[i], arch_reg_t'(field(p, F_EXP + 5*i)));
            check_tag("dp_rob_o.tag", dp_rob.tag[i], tag_t'(field(p, F_FTAG + i)));
            check_tag("dp_rob_o.tag_old", dp_rob.tag_old[i], tag_t'(field(p, F_OLD + i)));
        end
    endtask

    // count and valids cleared
    task automatic check_idle_regs();
        check_cnt("dp_rs_o.dp_num", dp_rs.dp_num, '0);
        check_cnt("dp_rob_o.dp_num", dp_rob.dp_num, '0);
        for (int i = 0; i < DP_NUM; i++) begin
            check_bit("dp_rs_o.valid", dp_rs.entry[i].valid, 1'b0);
            check_bit("dp_rob_o.valid", dp_rob.valid[i], 1'b0);
        end
    endtask

    initial begin
        clock_i     = 1'b0;
        rst_n_i     = 1'b0;
        rob_dp      = '0;
        fl_dp       = '0;
        fiq_dp      = '0;
        rs_dp       = '0;
        error_count = 0;
        cycle_count = 0;
        for (int i = 0; i < DP_NUM; i++) begin
            mt_dp[i] = '0;
        end
        $readmemh("dispatch_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*NUM_FIELD - 1])) begin
            error_count++;
            $display("vector file is missing or shorter than %0d records", NUM_VEC);
        end

        // reset with a full bundle on the inputs, nothing may rename
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clock_i);
            apply_vector(0);
            @(negedge clock_i);
            for (int i = 0; i < DP_NUM; i++) begin
                check_bit("dp_mt_o.wr_en", dp_mt[i].wr_en, 1'b0);
            end
            check_idle_regs();
        end

        for (int v = 0; v < NUM_VEC; v++) begin
            @(posedge clock_i);
            rst_n_i <= 1'b1;
            apply_vector(v);
            @(negedge clock_i);
            check_comb(v);
            // register still shows the last reset cycle
            if (v == 0) begin
                check_idle_regs();
            end else begin
                check_regd(v - 1);
            end
        end

        // drain the last vector
        @(posedge clock_i);
        rob_dp.free_num <= '0;
        @(negedge clock_i);
        check_regd(NUM_VEC - 1);

        $display("checked %0d vectors, %0d errors", NUM_VEC, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== dispatch_vectors.txt ====
// rob fl fiq rs | inst0 inst1 | pc0 pc1 | fltag0 fltag1 | robidx0 robidx1 | t1_0 t2_0 t1_1 t2_1
// old0 old1 | rdy | exp: num wr | rd rs1 rs2 func flags (lane0) | rd rs1 rs2 func flags (lane1)
2 2 2 2 00510093 005201B3 100 104 20 3f 00 1f 01 10 20 30 3f 00 5 2 3 01 02 00 0 01 03 04 05 0 01
3 3 3 3 40838333 02B504B3 108 10c 21 3e 01 1e 02 11 21 2f 3e 01 a 2 3 06 07 08 1 01 09 0a 0b a 02
2 1 2 2 02E6B633 023110B3 110 114 22 3d 02 1d 03 12 22 2e 3d 02 f 1 1 0c 0d 0e d 02 00 00 00 0 01
2 2 2 1 0262A233 123452B7 118 11c 23 3c 03 1c 04 13 23 2d 3c 03 0 1 1 04 05 06 c 02 00 00 00 0 01
2 2 2 2 123452B7 00001317 120 124 24 3b 04 1b 05 14 24 2c 3b 04 3 2 3 05 00 00 0 01 06 00 00 0 01
2 2 2 2 008000EF 00008067 128 12c 25 3a 05 1a 06 15 25 2b 3a 05 6 2 3 01 00 00 0 10 00 01 00 0 10
1 2 2 2 00208463 0041D063 130 134 26 39 06 19 07 16 26 2a 39 06 9 1 1 00 01 02 0 20 00 00 00 0 01
2 2 2 2 00208463 0041D063 138 13c 27 38 07 18 08 17 27 29 38 07 c 2 3 00 01 02 0 20 00 03 04 0 20
2 2 2 2 00442383 00054483 140 144 28 37 08 17 09 18 28 28 37 08 1 2 3 07 08 00 0 80 09 0a 00 0 80
2 2 2 2 00B62623 00110023 148 14c 29 36 09 16 0a 19 29 27 36 09 4 2 3 00 0c 0b 0 40 00 02 01 0 40
2 2 2 2 00221193 40335293 150 154 2a 35 0a 15 0b 1a 2a 26 35 0a 7 2 3 03 04 00 7 01 05 06 00 9 01
2 2 2 2 0010D093 0011B113 158 15c 2b 34 0b 14 0c 1b 2b 25 34 0b 8 2 3 01 01 00 8 01 02 03 00 3 01
2 2 2 2 0FF2F213 FFF3C313 160 164 2c 33 0c 13 0d 1c 2c 24 33 0c b 2 3 04 05 00 4 01 06 07 00 6 01
2 2 2 2 00A4E433 403150B3 168 16c 2d 32 0d 12 0e 1d 2d 23 32 0d e 2 3 08 09 0a 5 01 01 02 03 9 01
2 2 2 2 0041A133 10500073 170 174 2e 31 0e 11 0f 1e 2e 22 31 0e 2 2 3 02 03 04 2 01 00 00 00 0 09
2 2 2 2 30011073 00000073 178 17c 2f 30 0f 10 10 1f 2f 21 30 0f d 2 3 00 00 00 0 05 00 00 00 0 05
2 2 2 2 023140B3 FFFFFFFF 180 184 30 2f 10 0f 11 20 30 20 2f 10 5 2 3 00 00 00 0 05 00 00 00 0 05
0 2 2 2 00510093 005201B3 188 18c 31 2e 11 0e 12 21 31 1f 2e 11 f 0 0 00 00 00 0 01 00 00 00 0 01
2 0 2 2 00510093 005201B3 190 194 32 2d 12 0d 13 22 32 1e 2d 12 0 0 0 00 00 00 0 01 00 00 00 0 01
2 2 0 2 00510093 005201B3 198 19c 33 2c 13 0c 14 23 33 1d 2c 13 a 0 0 00 00 00 0 01 00 00 00 0 01
2 2 2 0 00510093 005201B3 1a0 1a4 34 2b 14 0b 15 24 34 1c 2b 14 6 0 0 00 00 00 0 01 00 00 00 0 01
3 1 3 3 005201B3 00510093 1a8 1ac 35 2a 15 0a 16 25 35 1b 2a 15 9 1 1 03 04 05 0 01 00 00 00 0 01
1 3 3 3 10500073 30011073 1b0 1b4 36 29 16 09 17 26 36 1a 29 16 3 1 1 00 00 00 0 09 00 00 00 0 01
3 3 2 3 02B504B3 0041A133 1b8 1bc 37 28 17 08 18 27 37 19 28 17 c 2 3 09 0a 0b a 02 02 03 04 2 01
3 3 3 3 00442383 40838333 1c0 1c4 38 27 18 07 19 28 38 18 27 18 5 2 3 07 08 00 0 80 06 07 08 1 01

// ==== project.f ====
dispatch_pkg.sv
dispatch_count.sv
rv32_decoder.sv
dispatch_stage.sv
tb_dispatch_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module tb_dispatch_stage -o sim_dispatch
./obj_dir/sim_dispatch > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
echo "simulation finished without failures"
